//--- eth_dma_fabric.f
tl_pkg.sv
dma_pkg.sv
dma_link_port.sv
dma_socket_m1.sv
eth_dma_fabric.sv
eth_dma_fabric_checker.sv
eth_dma_fabric_tb.sv

//--- run_sim.sh
#!/bin/bash
# Build and run the fabric testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module eth_dma_fabric_tb -f eth_dma_fabric.f || exit 1

out="$(./obj_dir/Veth_dma_fabric_tb)"
echo "$out"

echo "$out" | grep -qx "NO ERRORS" && exit 0 || exit 1

//--- eth_dma_fabric_tb.sv
`timescale 1ns/100ps
`default_nettype none

module eth_dma_fabric_tb
  import tl_pkg::*;
();

  localparam int unsigned HostSourceWidth = 1;
  localparam int unsigned MaxOutstanding  = 4;
  localparam int          Requests        = 400;
  localparam int          DirectedCycles  = 40;
  localparam int          TimeoutCycles   = Requests * 20 + 16 + DirectedCycles;

  logic clk_i = 1'b0;
  logic rst_i;

  logic                       dma_a_valid_i, sg_a_valid_i;
  tl_a_op_e                   dma_a_opcode_i, sg_a_opcode_i;
  logic [TlAddrWidth-1:0]     dma_a_address_i, sg_a_address_i;
  logic [TlDataWidth-1:0]     dma_a_data_i, sg_a_data_i;
  logic [TlMaskWidth-1:0]     dma_a_mask_i, sg_a_mask_i;
  logic [HostSourceWidth-1:0] dma_a_source_i, sg_a_source_i;
  logic                       dma_a_ready_o, sg_a_ready_o;
  logic                       dma_d_valid_o, sg_d_valid_o;
  tl_d_op_e                   dma_d_opcode_o, sg_d_opcode_o;
  logic [TlDataWidth-1:0]     dma_d_data_o, sg_d_data_o;
  logic [HostSourceWidth-1:0] dma_d_source_o, sg_d_source_o;
  logic                       dma_d_ready_i, sg_d_ready_i;

  logic                       mem_a_valid_o;
  tl_a_op_e                   mem_a_opcode_o;
  logic [TlAddrWidth-1:0]     mem_a_address_o;
  logic [TlDataWidth-1:0]     mem_a_data_o;
  logic [TlMaskWidth-1:0]     mem_a_mask_o;
  logic [HostSourceWidth:0]   mem_a_source_o;
  logic                       mem_a_ready_i;
  logic                       mem_d_valid_i;
  tl_d_op_e                   mem_d_opcode_i;
  logic [TlDataWidth-1:0]     mem_d_data_i;
  logic [HostSourceWidth:0]   mem_d_source_i;
  logic                       mem_d_ready_o;

  integer seed;
  int     cycle = 0;
  logic   directed = 1'b0;
  logic   saturated = 1'b0;
  int     dma_left = Requests;
  int     sg_left = Requests;
  int     dma_gap = 0;
  int     sg_gap = 0;
  int     value_errors, other_errors;
  logic   idle;

  // Memory responder state
  logic [TlDataWidth-1:0]     mem [256];
  tl_d_op_e                   rsp_op_q [$];
  logic [TlDataWidth-1:0]     rsp_data_q [$];
  logic [HostSourceWidth:0]   rsp_src_q [$];
  int                         rsp_due_q [$];
  int                         due;
  int                         last_due = 0;

  always #50 clk_i = ~clk_i;

  eth_dma_fabric #(
    .HostSourceWidth (HostSourceWidth),
    .MaxOutstanding  (MaxOutstanding)
  ) uut (.*);

  eth_dma_fabric_checker #(
    .HostSourceWidth (HostSourceWidth),
    .MaxOutstanding  (MaxOutstanding)
  ) scoreboard (
    .saturated_i    (saturated),
    .value_errors_o (value_errors),
    .other_errors_o (other_errors),
    .idle_o         (idle),
    .*
  );

  ////////////////////////////////////////
  // Host stimulus

  always @(posedge clk_i) begin
    if (rst_i) begin
      dma_a_valid_i <= 1'b0;
    end else if (!dma_a_valid_i || dma_a_ready_o) begin
      if (dma_left > 0 && (dma_gap == 0 || directed || saturated)) begin
        dma_a_valid_i   <= 1'b1;
        dma_a_opcode_i  <= ($random(seed) & 1) ? Get : PutFullData;
        dma_a_address_i <= {21'd0, 8'($random(seed)), 3'b000};
        dma_a_data_i    <= {$random(seed), $random(seed)};
        dma_a_mask_i    <= 8'($random(seed));
        dma_a_source_i  <= HostSourceWidth'($random(seed));
        dma_left        <= dma_left - 1;
        dma_gap         <= $unsigned($random(seed)) % 4;
      end else begin
        dma_a_valid_i <= 1'b0;
        if (dma_gap > 0) dma_gap <= dma_gap - 1;
      end
    end
  end

  always @(posedge clk_i) begin
    if (rst_i) begin
      sg_a_valid_i <= 1'b0;
    end else if (!sg_a_valid_i || sg_a_ready_o) begin
      if (sg_left > 0 && (sg_gap == 0 || directed || saturated)) begin
        sg_a_valid_i   <= 1'b1;
        sg_a_opcode_i  <= ($random(seed) & 1) ? Get : PutFullData;
        sg_a_address_i <= {21'd0, 8'($random(seed)), 3'b000};
        sg_a_data_i    <= {$random(seed), $random(seed)};
        sg_a_mask_i    <= 8'($random(seed));
        sg_a_source_i  <= HostSourceWidth'($random(seed));
        sg_left        <= sg_left - 1;
        sg_gap         <= $unsigned($random(seed)) % 4;
      end else begin
        sg_a_valid_i <= 1'b0;
        if (sg_gap > 0) sg_gap <= sg_gap - 1;
      end
    end
  end

  ////////////////////////////////////////
  // Downstream memory with in-order answers

  always @(posedge clk_i) begin
    if (rst_i) begin
      mem_a_ready_i <= 1'b0;
      mem_d_valid_i <= 1'b0;
    end else begin
      if (mem_a_valid_o && mem_a_ready_i) begin
        if (mem_a_opcode_o == Get) begin
          rsp_op_q.push_back(AccessAckData);
          rsp_data_q.push_back(mem[mem_a_address_o[10:3]]);
        end else begin
          rsp_op_q.push_back(AccessAck);
          rsp_data_q.push_back('0);
          for (int b = 0; b < TlMaskWidth; b++) begin
            if (mem_a_mask_o[b]) begin
              mem[mem_a_address_o[10:3]][8*b +: 8] = mem_a_data_o[8*b +: 8];
            end
          end
        end
        rsp_src_q.push_back(mem_a_source_o);
        due = cycle + int'($unsigned($random(seed)) % 6);
        if (due < last_due) due = last_due;
        last_due = due;
        rsp_due_q.push_back(due);
      end
      if (!mem_d_valid_i || mem_d_ready_o) begin
        if (rsp_due_q.size() > 0 && rsp_due_q[0] <= cycle) begin
          mem_d_valid_i  <= 1'b1;
          mem_d_opcode_i <= rsp_op_q.pop_front();
          mem_d_data_i   <= rsp_data_q.pop_front();
          mem_d_source_i <= rsp_src_q.pop_front();
          void'(rsp_due_q.pop_front());
        end else begin
          mem_d_valid_i <= 1'b0;
        end
      end
      mem_a_ready_i <= saturated ? 1'b1 : 1'($random(seed));
    end
    dma_d_ready_i <= directed ? 1'b0 : (saturated ? 1'b1 : 1'($random(seed)));
    sg_d_ready_i  <= directed ? 1'b0 : (saturated ? 1'b1 : 1'($random(seed)));
  end

  always @(posedge clk_i) begin
    cycle <= cycle + 1;
    if (cycle >= TimeoutCycles) begin
      $display("run timed out after %0d cycles with requests still pending", cycle);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  initial begin
    seed = 32'h2a28_72ee;
    rst_i = 1'b1;
    dma_a_valid_i = 1'b0;
    dma_a_opcode_i = Get;
    dma_a_address_i = '0;
    dma_a_data_i = '0;
    dma_a_mask_i = '0;
    dma_a_source_i = '0;
    dma_d_ready_i = 1'b0;
    sg_a_valid_i = 1'b0;
    sg_a_opcode_i = Get;
    sg_a_address_i = '0;
    sg_a_data_i = '0;
    sg_a_mask_i = '0;
    sg_a_source_i = '0;
    sg_d_ready_i = 1'b0;
    mem_a_ready_i = 1'b0;
    mem_d_valid_i = 1'b0;
    mem_d_opcode_i = AccessAck;
    mem_d_data_i = '0;
    mem_d_source_i = '0;
    for (int i = 0; i < 256; i++) begin
      mem[i] = {32'(i) * 32'h9e37_79b1, ~32'(i)};
    end
    repeat (16) @(posedge clk_i);
    rst_i <= 1'b0;
    // Responses held back so both hosts hit the in-flight limit
    directed <= 1'b1;
    repeat (DirectedCycles) @(posedge clk_i);
    directed <= 1'b0;
    while (dma_left > 100 || sg_left > 100) @(posedge clk_i);
    saturated <= 1'b1;
    while (!(dma_left == 0 && sg_left == 0 && !dma_a_valid_i && !sg_a_valid_i && idle)) begin
      @(posedge clk_i);
    end
    $display("error counts: %0d wrong values, %0d other failures", value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- eth_dma_fabric_checker.sv
`timescale 1ns/100ps
`default_nettype none

module eth_dma_fabric_checker
  import tl_pkg::*;
#(
  parameter int unsigned HostSourceWidth = 1,
  parameter int unsigned MaxOutstanding  = 4
) (
  input  wire                        clk_i,
  input  wire                        rst_i,
  input  wire                        saturated_i,
  input  wire                        dma_a_valid_i,
  input  tl_a_op_e                   dma_a_opcode_i,
  input  wire  [TlAddrWidth-1:0]     dma_a_address_i,
  input  wire  [TlDataWidth-1:0]     dma_a_data_i,
  input  wire  [TlMaskWidth-1:0]     dma_a_mask_i,
  input  wire  [HostSourceWidth-1:0] dma_a_source_i,
  input  wire                        dma_a_ready_o,
  input  wire                        dma_d_valid_o,
  input  tl_d_op_e                   dma_d_opcode_o,
  input  wire  [TlDataWidth-1:0]     dma_d_data_o,
  input  wire  [HostSourceWidth-1:0] dma_d_source_o,
  input  wire                        dma_d_ready_i,
  input  wire                        sg_a_valid_i,
  input  tl_a_op_e                   sg_a_opcode_i,
  input  wire  [TlAddrWidth-1:0]     sg_a_address_i,
  input  wire  [TlDataWidth-1:0]     sg_a_data_i,
  input  wire  [TlMaskWidth-1:0]     sg_a_mask_i,
  input  wire  [HostSourceWidth-1:0] sg_a_source_i,
  input  wire                        sg_a_ready_o,
  input  wire                        sg_d_valid_o,
  input  tl_d_op_e                   sg_d_opcode_o,
  input  wire  [TlDataWidth-1:0]     sg_d_data_o,
  input  wire  [HostSourceWidth-1:0] sg_d_source_o,
  input  wire                        sg_d_ready_i,
  input  wire                        mem_a_valid_o,
  input  tl_a_op_e                   mem_a_opcode_o,
  input  wire  [TlAddrWidth-1:0]     mem_a_address_o,
  input  wire  [TlDataWidth-1:0]     mem_a_data_o,
  input  wire  [TlMaskWidth-1:0]     mem_a_mask_o,
  input  wire  [HostSourceWidth:0]   mem_a_source_o,
  input  wire                        mem_a_ready_i,
  input  wire                        mem_d_valid_i,
  input  wire  [HostSourceWidth:0]   mem_d_source_i,
  input  wire                        mem_d_ready_o,
  output int                         value_errors_o,
  output int                         other_errors_o,
  output logic                       idle_o
);

  typedef struct packed {
    tl_a_op_e                   op;
    logic [TlAddrWidth-1:0]     addr;
    logic [TlDataWidth-1:0]     data;
    logic [TlMaskWidth-1:0]     mask;
    logic [HostSourceWidth-1:0] src;
  } req_t;

  typedef struct packed {
    tl_d_op_e                   op;
    logic [TlDataWidth-1:0]     data;
    logic [HostSourceWidth-1:0] src;
  } rsp_t;

  req_t                   req_q [2][$];
  rsp_t                   rsp_q [2][$];
  int                     outstanding [2];
  logic [TlDataWidth-1:0] mem [256];
  logic                   rst_prev = 1'b0;
  logic [1:0]             sat_hist = 2'b00;
  logic                   last_top = 1'b0;

  initial begin
    value_errors_o = 0;
    other_errors_o = 0;
    idle_o         = 1'b1;
    // Initial contents as in the memory responder
    for (int i = 0; i < 256; i++) begin
      mem[i] = {32'(i) * 32'h9e37_79b1, ~32'(i)};
    end
  end

  task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("FAIL %s expected %h actual %h", name, exp, act);
      value_errors_o++;
    end
  endtask

  task automatic host_request(input int h, input req_t r);
    req_q[h].push_back(r);
    outstanding[h]++;
  endtask

  task automatic limit_check(input int h, input logic ready, input string name);
    if (outstanding[h] > int'(MaxOutstanding)) begin
      $display("%s host has %0d requests in flight, above the limit", name, outstanding[h]);
      other_errors_o++;
    end else if (outstanding[h] == int'(MaxOutstanding) && ready) begin
      $display("%s host accepts requests while at the in-flight limit", name);
      other_errors_o++;
    end
  endtask

  ////////////////////////////////////////
  // Downstream request and memory model

  task automatic memory_request();
    int   h;
    req_t r;
    rsp_t e;
    h = int'(mem_a_source_o[HostSourceWidth]);
    if (req_q[h].size() == 0) begin
      $display("memory request for link %0d with no host request pending", h);
      other_errors_o++;
      return;
    end
    r = req_q[h].pop_front();
    compare("mem_a_opcode_o", 64'(r.op), 64'(mem_a_opcode_o));
    compare("mem_a_address_o", 64'(r.addr), 64'(mem_a_address_o));
    compare("mem_a_data_o", r.data, mem_a_data_o);
    compare("mem_a_mask_o", 64'(r.mask), 64'(mem_a_mask_o));
    compare("mem_a_source_o", 64'(r.src), 64'(mem_a_source_o[HostSourceWidth-1:0]));
    e.src = r.src;
    if (r.op == Get) begin
      e.op   = AccessAckData;
      e.data = mem[r.addr[10:3]];
    end else begin
      e.op   = AccessAck;
      e.data = '0;
      for (int b = 0; b < TlMaskWidth; b++) begin
        if (r.mask[b]) mem[r.addr[10:3]][8*b +: 8] = r.data[8*b +: 8];
      end
    end
    rsp_q[h].push_back(e);
  endtask

  task automatic host_response(input int h, input tl_d_op_e op, input logic [63:0] data,
                               input logic [HostSourceWidth-1:0] src, input string name);
    rsp_t e;
    if (rsp_q[h].size() == 0) begin
      $display("%s host got a response with no request outstanding", name);
      other_errors_o++;
      return;
    end
    e = rsp_q[h].pop_front();
    outstanding[h]--;
    compare({name, "_d_opcode_o"}, 64'(e.op), 64'(op));
    compare({name, "_d_source_o"}, 64'(e.src), 64'(src));
    if (e.op == AccessAckData) compare({name, "_d_data_o"}, e.data, data);
  endtask

  always @(posedge clk_i) begin
    if (rst_prev) begin
      if (mem_a_valid_o || dma_d_valid_o || sg_d_valid_o || !dma_a_ready_o || !sg_a_ready_o) begin
        $display("outputs not at their reset values during or after reset");
        other_errors_o++;
      end
    end
    if (rst_i) begin
      outstanding[0] = 0;
      outstanding[1] = 0;
    end else begin
      limit_check(0, dma_a_ready_o, "dma");
      limit_check(1, sg_a_ready_o, "sg");
      if (mem_d_valid_i) begin
        // Back-pressure comes from the host the response is for
        compare("mem_d_ready_o",
                64'(mem_d_source_i[HostSourceWidth] ? sg_d_ready_i : dma_d_ready_i),
                64'(mem_d_ready_o));
      end
      if (mem_a_valid_o && mem_a_ready_i) begin
        // Round-robin once both links hold a request
        if (sat_hist == 2'b11 && req_q[0].size() > 0 && req_q[1].size() > 0
            && mem_a_source_o[HostSourceWidth] == last_top) begin
          $display("arbiter granted link %0d twice in a row", last_top);
          other_errors_o++;
        end
        last_top = mem_a_source_o[HostSourceWidth];
        memory_request();
      end
      if (dma_a_valid_i && dma_a_ready_o) begin
        host_request(0, {dma_a_opcode_i, dma_a_address_i, dma_a_data_i, dma_a_mask_i,
                         dma_a_source_i});
      end
      if (sg_a_valid_i && sg_a_ready_o) begin
        host_request(1, {sg_a_opcode_i, sg_a_address_i, sg_a_data_i, sg_a_mask_i,
                         sg_a_source_i});
      end
      if (dma_d_valid_o && dma_d_ready_i) begin
        host_response(0, dma_d_opcode_o, dma_d_data_o, dma_d_source_o, "dma");
      end
      if (sg_d_valid_o && sg_d_ready_i) begin
        host_response(1, sg_d_opcode_o, sg_d_data_o, sg_d_source_o, "sg");
      end
    end
    rst_prev = rst_i;
    sat_hist = {sat_hist[0], saturated_i};
    idle_o   = req_q[0].size() == 0 && req_q[1].size() == 0
               && rsp_q[0].size() == 0 && rsp_q[1].size() == 0;
  end

endmodule

`default_nettype wire

//--- eth_dma_fabric.sv
`timescale 1ns/100ps
`default_nettype none

module eth_dma_fabric
  import tl_pkg::*;
  import dma_pkg::*;
#(
  parameter int unsigned HostSourceWidth = 1,
  parameter int unsigned MaxOutstanding  = DefaultMaxOutstanding
) (
  input  wire                        clk_i,
  input  wire                        rst_i,

  // Bulk data host
  input  wire                        dma_a_valid_i,
  input  tl_a_op_e                   dma_a_opcode_i,
  input  wire  [TlAddrWidth-1:0]     dma_a_address_i,
  input  wire  [TlDataWidth-1:0]     dma_a_data_i,
  input  wire  [TlMaskWidth-1:0]     dma_a_mask_i,
  input  wire  [HostSourceWidth-1:0] dma_a_source_i,
  output logic                       dma_a_ready_o,
  output logic                       dma_d_valid_o,
  output tl_d_op_e                   dma_d_opcode_o,
  output logic [TlDataWidth-1:0]     dma_d_data_o,
  output logic [HostSourceWidth-1:0] dma_d_source_o,
  input  wire                        dma_d_ready_i,

  // Descriptor host
  input  wire                        sg_a_valid_i,
  input  tl_a_op_e                   sg_a_opcode_i,
  input  wire  [TlAddrWidth-1:0]     sg_a_address_i,
  input  wire  [TlDataWidth-1:0]     sg_a_data_i,
  input  wire  [TlMaskWidth-1:0]     sg_a_mask_i,
  input  wire  [HostSourceWidth-1:0] sg_a_source_i,
  output logic                       sg_a_ready_o,
  output logic                       sg_d_valid_o,
  output tl_d_op_e                   sg_d_opcode_o,
  output logic [TlDataWidth-1:0]     sg_d_data_o,
  output logic [HostSourceWidth-1:0] sg_d_source_o,
  input  wire                        sg_d_ready_i,

  // Downstream memory link
  output logic                       mem_a_valid_o,
  output tl_a_op_e                   mem_a_opcode_o,
  output logic [TlAddrWidth-1:0]     mem_a_address_o,
  output logic [TlDataWidth-1:0]     mem_a_data_o,
  output logic [TlMaskWidth-1:0]     mem_a_mask_o,
  output logic [HostSourceWidth:0]   mem_a_source_o,
  input  wire                        mem_a_ready_i,
  input  wire                        mem_d_valid_i,
  input  tl_d_op_e                   mem_d_opcode_i,
  input  wire  [TlDataWidth-1:0]     mem_d_data_i,
  input  wire  [HostSourceWidth:0]   mem_d_source_i,
  output logic                       mem_d_ready_o
);

  // Port to socket, indexed by link
  logic [NumLinks-1:0]      link_a_valid;
  tl_a_op_e                 link_a_opcode  [NumLinks];
  logic [TlAddrWidth-1:0]   link_a_address [NumLinks];
  logic [TlDataWidth-1:0]   link_a_data    [NumLinks];
  logic [TlMaskWidth-1:0]   link_a_mask    [NumLinks];
  logic [HostSourceWidth:0] link_a_source  [NumLinks];
  logic [NumLinks-1:0]      link_a_ready;
  logic [NumLinks-1:0]      link_d_valid;
  tl_d_op_e                 link_d_opcode  [NumLinks];
  logic [TlDataWidth-1:0]   link_d_data    [NumLinks];
  logic [HostSourceWidth:0] link_d_source  [NumLinks];
  logic [NumLinks-1:0]      link_d_ready;

  ////////////////////////////////////////
  // Link ports

  dma_link_port #(
    .HostSourceWidth (HostSourceWidth),
    .MaxOutstanding  (MaxOutstanding),
    .LinkIndex       (LinkData)
  ) data_port (
    .clk_i,
    .rst_i,
    .host_a_valid_i   (dma_a_valid_i),
    .host_a_opcode_i  (dma_a_opcode_i),
    .host_a_address_i (dma_a_address_i),
    .host_a_data_i    (dma_a_data_i),
    .host_a_mask_i    (dma_a_mask_i),
    .host_a_source_i  (dma_a_source_i),
    .host_a_ready_o   (dma_a_ready_o),
    .host_d_valid_o   (dma_d_valid_o),
    .host_d_opcode_o  (dma_d_opcode_o),
    .host_d_data_o    (dma_d_data_o),
    .host_d_source_o  (dma_d_source_o),
    .host_d_ready_i   (dma_d_ready_i),
    .link_a_valid_o   (link_a_valid[LinkData]),
    .link_a_opcode_o  (link_a_opcode[LinkData]),
    .link_a_address_o (link_a_address[LinkData]),
    .link_a_data_o    (link_a_data[LinkData]),
    .link_a_mask_o    (link_a_mask[LinkData]),
    .link_a_source_o  (link_a_source[LinkData]),
    .link_a_ready_i   (link_a_ready[LinkData]),
    .link_d_valid_i   (link_d_valid[LinkData]),
    .link_d_opcode_i  (link_d_opcode[LinkData]),
    .link_d_data_i    (link_d_data[LinkData]),
    .link_d_source_i  (link_d_source[LinkData]),
    .link_d_ready_o   (link_d_ready[LinkData])
  );

  dma_link_port #(
    .HostSourceWidth (HostSourceWidth),
    .MaxOutstanding  (MaxOutstanding),
    .LinkIndex       (LinkSg)
  ) sg_port (
    .clk_i,
    .rst_i,
    .host_a_valid_i   (sg_a_valid_i),
    .host_a_opcode_i  (sg_a_opcode_i),
    .host_a_address_i (sg_a_address_i),
    .host_a_data_i    (sg_a_data_i),
    .host_a_mask_i    (sg_a_mask_i),
    .host_a_source_i  (sg_a_source_i),
    .host_a_ready_o   (sg_a_ready_o),
    .host_d_valid_o   (sg_d_valid_o),
    .host_d_opcode_o  (sg_d_opcode_o),
    .host_d_data_o    (sg_d_data_o),
    .host_d_source_o  (sg_d_source_o),
    .host_d_ready_i   (sg_d_ready_i),
    .link_a_valid_o   (link_a_valid[LinkSg]),
    .link_a_opcode_o  (link_a_opcode[LinkSg]),
    .link_a_address_o (link_a_address[LinkSg]),
    .link_a_data_o    (link_a_data[LinkSg]),
    .link_a_mask_o    (link_a_mask[LinkSg]),
    .link_a_source_o  (link_a_source[LinkSg]),
    .link_a_ready_i   (link_a_ready[LinkSg]),
    .link_d_valid_i   (link_d_valid[LinkSg]),
    .link_d_opcode_i  (link_d_opcode[LinkSg]),
    .link_d_data_i    (link_d_data[LinkSg]),
    .link_d_source_i  (link_d_source[LinkSg]),
    .link_d_ready_o   (link_d_ready[LinkSg])
  );

  ////////////////////////////////////////
  // Socket onto the memory link

  dma_socket_m1 #(
    .HostSourceWidth (HostSourceWidth)
  ) dma_socket (
    .clk_i,
    .rst_i,
    .l0_a_valid_i    (link_a_valid[LinkData]),
    .l0_a_opcode_i   (link_a_opcode[LinkData]),
    .l0_a_address_i  (link_a_address[LinkData]),
    .l0_a_data_i     (link_a_data[LinkData]),
    .l0_a_mask_i     (link_a_mask[LinkData]),
    .l0_a_source_i   (link_a_source[LinkData]),
    .l0_a_ready_o    (link_a_ready[LinkData]),
    .l1_a_valid_i    (link_a_valid[LinkSg]),
    .l1_a_opcode_i   (link_a_opcode[LinkSg]),
    .l1_a_address_i  (link_a_address[LinkSg]),
    .l1_a_data_i     (link_a_data[LinkSg]),
    .l1_a_mask_i     (link_a_mask[LinkSg]),
    .l1_a_source_i   (link_a_source[LinkSg]),
    .l1_a_ready_o    (link_a_ready[LinkSg]),
    .l0_d_valid_o    (link_d_valid[LinkData]),
    .l0_d_opcode_o   (link_d_opcode[LinkData]),
    .l0_d_data_o     (link_d_data[LinkData]),
    .l0_d_source_o   (link_d_source[LinkData]),
    .l0_d_ready_i    (link_d_ready[LinkData]),
    .l1_d_valid_o    (link_d_valid[LinkSg]),
    .l1_d_opcode_o   (link_d_opcode[LinkSg]),
    .l1_d_data_o     (link_d_data[LinkSg]),
    .l1_d_source_o   (link_d_source[LinkSg]),
    .l1_d_ready_i    (link_d_ready[LinkSg]),
    .mem_a_valid_o,
    .mem_a_opcode_o,
    .mem_a_address_o,
    .mem_a_data_o,
    .mem_a_mask_o,
    .mem_a_source_o,
    .mem_a_ready_i,
    .mem_d_valid_i,
    .mem_d_opcode_i,
    .mem_d_data_i,
    .mem_d_source_i,
    .mem_d_ready_o
  );

endmodule

`default_nettype wire

//--- dma_socket_m1.sv
`timescale 1ns/100ps
`default_nettype none

module dma_socket_m1
  import tl_pkg::*;
  import dma_pkg::*;
#(
  parameter int unsigned HostSourceWidth = 1
) (
  input  wire                      clk_i,
  input  wire                      rst_i,

  input  wire                      l0_a_valid_i,
  input  tl_a_op_e                 l0_a_opcode_i,
  input  wire  [TlAddrWidth-1:0]   l0_a_address_i,
  input  wire  [TlDataWidth-1:0]   l0_a_data_i,
  input  wire  [TlMaskWidth-1:0]   l0_a_mask_i,
  input  wire  [HostSourceWidth:0] l0_a_source_i,
  output logic                     l0_a_ready_o,

  input  wire                      l1_a_valid_i,
  input  tl_a_op_e                 l1_a_opcode_i,
  input  wire  [TlAddrWidth-1:0]   l1_a_address_i,
  input  wire  [TlDataWidth-1:0]   l1_a_data_i,
  input  wire  [TlMaskWidth-1:0]   l1_a_mask_i,
  input  wire  [HostSourceWidth:0] l1_a_source_i,
  output logic                     l1_a_ready_o,

  output logic                     l0_d_valid_o,
  output tl_d_op_e                 l0_d_opcode_o,
  output logic [TlDataWidth-1:0]   l0_d_data_o,
  output logic [HostSourceWidth:0] l0_d_source_o,
  input  wire                      l0_d_ready_i,

  output logic                     l1_d_valid_o,
  output tl_d_op_e                 l1_d_opcode_o,
  output logic [TlDataWidth-1:0]   l1_d_data_o,
  output logic [HostSourceWidth:0] l1_d_source_o,
  input  wire                      l1_d_ready_i,

  output logic                     mem_a_valid_o,
  output tl_a_op_e                 mem_a_opcode_o,
  output logic [TlAddrWidth-1:0]   mem_a_address_o,
  output logic [TlDataWidth-1:0]   mem_a_data_o,
  output logic [TlMaskWidth-1:0]   mem_a_mask_o,
  output logic [HostSourceWidth:0] mem_a_source_o,
  input  wire                      mem_a_ready_i,

  input  wire                      mem_d_valid_i,
  input  tl_d_op_e                 mem_d_opcode_i,
  input  wire  [TlDataWidth-1:0]   mem_d_data_i,
  input  wire  [HostSourceWidth:0] mem_d_source_i,
  output logic                     mem_d_ready_o
);

  localparam logic SelData = 1'(LinkData);
  localparam logic SelSg   = 1'(LinkSg);

  logic grant;
  logic last_q;
  logic hold_q;
  logic hold_link_q;
  logic mem_a_fire;
  logic rsp_sel;

  ////////////////////////////////////////
  // Request arbitration

  // Round-robin on a tie, locked while the downstream stalls
  always_comb begin
    if (hold_q) begin
      grant = hold_link_q;
    end else if (l0_a_valid_i && l1_a_valid_i) begin
      grant = ~last_q;
    end else if (l1_a_valid_i) begin
      grant = SelSg;
    end else begin
      grant = SelData;
    end
  end

  assign mem_a_fire = mem_a_valid_o && mem_a_ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      last_q      <= SelSg;
      hold_q      <= 1'b0;
      hold_link_q <= SelData;
    end else begin
      if (mem_a_fire) begin
        last_q <= grant;
      end
      hold_q      <= mem_a_valid_o && !mem_a_ready_i;
      hold_link_q <= grant;
    end
  end

  assign mem_a_valid_o   = (grant == SelSg) ? l1_a_valid_i   : l0_a_valid_i;
  assign mem_a_opcode_o  = (grant == SelSg) ? l1_a_opcode_i  : l0_a_opcode_i;
  assign mem_a_address_o = (grant == SelSg) ? l1_a_address_i : l0_a_address_i;
  assign mem_a_data_o    = (grant == SelSg) ? l1_a_data_i    : l0_a_data_i;
  assign mem_a_mask_o    = (grant == SelSg) ? l1_a_mask_i    : l0_a_mask_i;
  assign mem_a_source_o  = (grant == SelSg) ? l1_a_source_i  : l0_a_source_i;

  assign l0_a_ready_o = mem_a_ready_i && (grant == SelData);
  assign l1_a_ready_o = mem_a_ready_i && (grant == SelSg);

  ////////////////////////////////////////
  // Response routing

  // Top source bit names the link
  assign rsp_sel = mem_d_source_i[HostSourceWidth];

  assign l0_d_valid_o  = mem_d_valid_i && (rsp_sel == SelData);
  assign l0_d_opcode_o = mem_d_opcode_i;
  assign l0_d_data_o   = mem_d_data_i;
  assign l0_d_source_o = mem_d_source_i;

  assign l1_d_valid_o  = mem_d_valid_i && (rsp_sel == SelSg);
  assign l1_d_opcode_o = mem_d_opcode_i;
  assign l1_d_data_o   = mem_d_data_i;
  assign l1_d_source_o = mem_d_source_i;

  assign mem_d_ready_o = (rsp_sel == SelSg) ? l1_d_ready_i : l0_d_ready_i;

endmodule

`default_nettype wire

//--- dma_link_port.sv
`timescale 1ns/100ps
`default_nettype none

module dma_link_port
  import tl_pkg::*;
  import dma_pkg::*;
#(
  parameter int unsigned HostSourceWidth = 1,
  parameter int unsigned MaxOutstanding  = DefaultMaxOutstanding,
  parameter int unsigned LinkIndex       = LinkData
) (
  input  wire                        clk_i,
  input  wire                        rst_i,

  input  wire                        host_a_valid_i,
  input  tl_a_op_e                   host_a_opcode_i,
  input  wire  [TlAddrWidth-1:0]     host_a_address_i,
  input  wire  [TlDataWidth-1:0]     host_a_data_i,
  input  wire  [TlMaskWidth-1:0]     host_a_mask_i,
  input  wire  [HostSourceWidth-1:0] host_a_source_i,
  output logic                       host_a_ready_o,

  output logic                       host_d_valid_o,
  output tl_d_op_e                   host_d_opcode_o,
  output logic [TlDataWidth-1:0]     host_d_data_o,
  output logic [HostSourceWidth-1:0] host_d_source_o,
  input  wire                        host_d_ready_i,

  output logic                       link_a_valid_o,
  output tl_a_op_e                   link_a_opcode_o,
  output logic [TlAddrWidth-1:0]     link_a_address_o,
  output logic [TlDataWidth-1:0]     link_a_data_o,
  output logic [TlMaskWidth-1:0]     link_a_mask_o,
  output logic [HostSourceWidth:0]   link_a_source_o,
  input  wire                        link_a_ready_i,

  input  wire                        link_d_valid_i,
  input  tl_d_op_e                   link_d_opcode_i,
  input  wire  [TlDataWidth-1:0]     link_d_data_i,
  input  wire  [HostSourceWidth:0]   link_d_source_i,
  output logic                       link_d_ready_o
);

  localparam int unsigned CntWidth = $clog2(MaxOutstanding + 1);
  localparam logic        LinkBit  = 1'(LinkIndex);

  // Two-entry skid buffer for the payload
  tl_a_op_e                   buf_opcode  [2];
  logic [TlAddrWidth-1:0]     buf_address [2];
  logic [TlDataWidth-1:0]     buf_data    [2];
  logic [TlMaskWidth-1:0]     buf_mask    [2];
  logic [HostSourceWidth-1:0] buf_source  [2];

  logic                wr_ptr_q;
  logic                rd_ptr_q;
  logic [1:0]          count_q;
  logic [CntWidth-1:0] inflight_q;

  logic req_fire;
  logic link_fire;
  logic rsp_fire;

  ////////////////////////////////////////
  // Request side

  // Stall on a full buffer or at the in-flight limit
  assign host_a_ready_o = (count_q != 2'd2) && (inflight_q != CntWidth'(MaxOutstanding));
  assign req_fire       = host_a_valid_i && host_a_ready_o;
  assign link_fire      = link_a_valid_o && link_a_ready_i;

  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      buf_opcode[wr_ptr_q]  <= host_a_opcode_i;
      buf_address[wr_ptr_q] <= host_a_address_i;
      buf_data[wr_ptr_q]    <= host_a_data_i;
      buf_mask[wr_ptr_q]    <= host_a_mask_i;
      buf_source[wr_ptr_q]  <= host_a_source_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else begin
      if (req_fire) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (link_fire) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      case ({req_fire, link_fire})
        2'b10:   count_q <= count_q + 2'd1;
        2'b01:   count_q <= count_q - 2'd1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Oldest entry goes out first
  assign link_a_valid_o   = count_q != 2'd0;
  assign link_a_opcode_o  = buf_opcode[rd_ptr_q];
  assign link_a_address_o = buf_address[rd_ptr_q];
  assign link_a_data_o    = buf_data[rd_ptr_q];
  assign link_a_mask_o    = buf_mask[rd_ptr_q];
  assign link_a_source_o  = {LinkBit, buf_source[rd_ptr_q]};

  ////////////////////////////////////////
  // In-flight tracking

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      inflight_q <= '0;
    end else if (req_fire && !rsp_fire) begin
      inflight_q <= inflight_q + CntWidth'(1);
    end else if (rsp_fire && !req_fire) begin
      inflight_q <= inflight_q - CntWidth'(1);
    end
  end

  ////////////////////////////////////////
  // Response side

  // Link bit dropped on the way back to the host
  assign host_d_valid_o  = link_d_valid_i;
  assign host_d_opcode_o = link_d_opcode_i;
  assign host_d_data_o   = link_d_data_i;
  assign host_d_source_o = link_d_source_i[HostSourceWidth-1:0];
  assign link_d_ready_o  = host_d_ready_i;
  assign rsp_fire        = host_d_valid_o && host_d_ready_i;

endmodule

`default_nettype wire

//--- dma_pkg.sv
`default_nettype none

package dma_pkg;

  ////////////////////////////////////////
  // Link indices on the downstream link

  // Bulk frame data host
  parameter int unsigned LinkData = 0;
  // Scatter-gather descriptor host
  parameter int unsigned LinkSg   = 1;

  parameter int unsigned NumLinks = 2;

  ////////////////////////////////////////
  // Flow control

  // Requests in flight per link
  parameter int unsigned DefaultMaxOutstanding = 4;

endpackage

`default_nettype wire

//--- tl_pkg.sv
`default_nettype none

package tl_pkg;

  ////////////////////////////////////////
  // Bus widths

  parameter int unsigned TlAddrWidth = 32;
  parameter int unsigned TlDataWidth = 64;
  // One mask bit per data byte
  parameter int unsigned TlMaskWidth = TlDataWidth / 8;

  ////////////////////////////////////////
  // Opcodes

  // A channel, single beat only
  typedef enum logic [2:0] {
    PutFullData = 3'd0,
    Get         = 3'd4
  } tl_a_op_e;

  // D channel
  typedef enum logic [2:0] {
    AccessAck     = 3'd0,
    AccessAckData = 3'd1
  } tl_d_op_e;

endpackage

`default_nettype wire
